// File: Makefile
TOP := tb_xor_regfile

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f -Mdir obj_dir
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only -Wall --timing --top-module xor_regfile -f filelist.f

clean:
	rm -rf obj_dir

// File: filelist.f
logic/regfile_types_pkg.sv
logic/regfile_geom_pkg.sv
logic/bank_wr_if.sv
logic/sdp_bwe_ram.sv
logic/xor_bank.sv
logic/write_encoder.sv
logic/read_decoder.sv
logic/xor_regfile.sv
testbench/tb_xor_regfile.sv

// File: logic/bank_wr_if.sv
`default_nettype none

interface bank_wr_if #(
   parameter int W_PORTS = 2
);
   import regfile_types_pkg::*;

   // one feedback copy per other write port
   localparam int FB_N = W_PORTS - 1;

   // registered write, already XOR encoded
   addr_t waddr;
   bwe_t  wbe;
   data_t wdata;

   // feedback reads, indexed by copy number
   addr_t [FB_N-1:0] fb_raddr;
   data_t [FB_N-1:0] fb_rdata;

   modport encoder (
      output waddr, wbe, wdata, fb_raddr,
      input  fb_rdata
   );

   modport bank (
      input  waddr, wbe, wdata, fb_raddr,
      output fb_rdata
   );

endinterface

`default_nettype wire

// File: logic/read_decoder.sv
`default_nettype none

module read_decoder #(
   parameter int W_PORTS = 2,
   parameter int R_PORTS = 4
) (
   input  logic                                                clk,
   input  logic                                                rstn,
   input  logic [R_PORTS-1:0]                                  ren_i,
   input  regfile_types_pkg::data_t [W_PORTS-1:0][R_PORTS-1:0] bank_data_i,
   output regfile_types_pkg::data_t [R_PORTS-1:0]              rdata_o,
   output logic [R_PORTS-1:0]                                  rvalid_o
);
   import regfile_types_pkg::*;

   logic  [R_PORTS-1:0] ren_q;
   logic  [R_PORTS-1:0] vld_q;
   data_t [R_PORTS-1:0] xor_c;
   data_t [R_PORTS-1:0] xor_q;

   // fold all banks for each read port
   always_comb
   begin
      for (int r = 0; r < R_PORTS; r++)
      begin
         xor_c[r] = '0;
         for (int b = 0; b < W_PORTS; b++)
         begin
            xor_c[r] = xor_c[r] ^ bank_data_i[b][r];
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         ren_q    <= '0;
         vld_q    <= '0;
         rvalid_o <= '0;
      end
      else
      begin
         ren_q    <= ren_i;   // lines up with RAM output
         vld_q    <= ren_q;
         rvalid_o <= vld_q;
      end
   end

   // xor tree registered before the output stage
   always_ff @(posedge clk)
   begin
      for (int r = 0; r < R_PORTS; r++)
      begin
         if (ren_q[r])
         begin
            xor_q[r] <= xor_c[r];
         end
         if (vld_q[r])
         begin
            rdata_o[r] <= xor_q[r];
         end
      end
   end

   a_rvalid_known: assert property (@(posedge clk) disable iff (!rstn) !$isunknown(rvalid_o));

endmodule

`default_nettype wire

// File: logic/regfile_geom_pkg.sv
`default_nettype none

package regfile_geom_pkg;

   // the encoder is sized for at most this many write ports
   localparam int MAX_W_PORTS = 4;

   // feedback copy in bank "bank" that serves write port "port"
   // copies are numbered over the other ports in ascending order,
   // so ports above the owner shift down by one
   function automatic int fb_index(input int bank, input int port);
      int idx;
      if (port < bank)
      begin
         idx = port;
      end
      else
      begin
         idx = port - 1;
      end
      return idx;
   endfunction

endpackage

`default_nettype wire

// File: logic/regfile_types_pkg.sv
`default_nettype none

package regfile_types_pkg;

   // register geometry
   localparam int DATA_W = 32;
   localparam int DEPTH  = 64;

   // byte lanes for the write enables
   localparam int BYTE_W = 8;
   localparam int NBYTES = DATA_W / BYTE_W;

   localparam int ADDR_W = $clog2(DEPTH);

   // one register value
   typedef logic [DATA_W-1:0] data_t;

   // register index
   typedef logic [ADDR_W-1:0] addr_t;

   // one enable bit per byte lane
   typedef logic [NBYTES-1:0] bwe_t;

endpackage

`default_nettype wire

// File: logic/sdp_bwe_ram.sv
`default_nettype none

module sdp_bwe_ram (
   input  logic                     clk,
   // write port
   input  regfile_types_pkg::addr_t a_addr_i,
   input  regfile_types_pkg::bwe_t  a_bwe_i,
   input  regfile_types_pkg::data_t a_data_i,
   // read port
   input  regfile_types_pkg::addr_t b_addr_i,
   input  logic                     b_en_i,
   output regfile_types_pkg::data_t b_data_o
);
   import regfile_types_pkg::*;

   data_t mem [DEPTH];

   // byte lane writes
   always_ff @(posedge clk)
   begin
      for (int b = 0; b < NBYTES; b++)
      begin
         if (a_bwe_i[b])
         begin
            mem[a_addr_i][b*BYTE_W +: BYTE_W] <= a_data_i[b*BYTE_W +: BYTE_W];
         end
      end
   end

   // registered read, old contents on a same-edge collision
   always_ff @(posedge clk)
   begin
      if (b_en_i)
      begin
         b_data_o <= mem[b_addr_i];
      end
   end

endmodule

`default_nettype wire

// File: logic/write_encoder.sv
`default_nettype none

module write_encoder #(
   parameter int W_PORTS = 2
) (
   input  logic                                   clk,
   input  logic                                   rstn,
   input  regfile_types_pkg::addr_t [W_PORTS-1:0] waddr_i,
   input  regfile_types_pkg::bwe_t  [W_PORTS-1:0] wbe_i,
   input  regfile_types_pkg::data_t [W_PORTS-1:0] wdata_i,
   bank_wr_if.encoder                             wr [W_PORTS]
);
   import regfile_types_pkg::*;
   import regfile_geom_pkg::*;

   // input registers
   addr_t [W_PORTS-1:0] waddr_q;
   bwe_t  [W_PORTS-1:0] wbe_q;
   data_t [W_PORTS-1:0] wdata_q;

   // what each bank wrote on the last edge
   addr_t [W_PORTS-1:0] hist_addr;
   bwe_t  [W_PORTS-1:0] hist_bwe;
   data_t [W_PORTS-1:0] hist_data;

   // bank q contents as seen by port p, own data on the diagonal
   data_t [W_PORTS-1:0][W_PORTS-1:0] fb_val;
   data_t [W_PORTS-1:0]              enc;
   logic                             wr_clash;

   function automatic data_t byte_mask(input bwe_t be);
      data_t m;
      for (int b = 0; b < NBYTES; b++)
      begin
         m[b*BYTE_W +: BYTE_W] = {BYTE_W{be[b]}};
      end
      return m;
   endfunction

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         wbe_q    <= '0;
         hist_bwe <= '0;
      end
      else
      begin
         wbe_q    <= wbe_i;
         hist_bwe <= wbe_q;
      end
   end

   always_ff @(posedge clk)
   begin
      waddr_q   <= waddr_i;
      wdata_q   <= wdata_i;
      hist_addr <= waddr_q;
      hist_data <= enc;
   end

   for (genvar p = 0; p < W_PORTS; p++)
   begin : g_port
      for (genvar q = 0; q < W_PORTS; q++)
      begin : g_bank
         if (q == p)
         begin : g_own
            assign fb_val[p][q] = wdata_q[p];
         end
         else
         begin : g_other
            localparam int FB = fb_index(q, p);
            data_t fwd_mask;

            // feedback copy latches the raw address with the input register
            assign wr[q].fb_raddr[FB] = waddr_i[p];

            // bank q wrote this address one edge ago, RAM still shows old bytes
            assign fwd_mask = (hist_addr[q] == waddr_q[p]) ? byte_mask(hist_bwe[q]) : '0;
            assign fb_val[p][q] = (wr[q].fb_rdata[FB] & ~fwd_mask)
                                | (hist_data[q] & fwd_mask);
         end
      end

      assign wr[p].waddr = waddr_q[p];
      assign wr[p].wbe   = wbe_q[p];
      assign wr[p].wdata = enc[p];
   end

   always_comb
   begin
      for (int p = 0; p < W_PORTS; p++)
      begin
         enc[p] = '0;
         for (int q = 0; q < W_PORTS; q++)
         begin
            enc[p] = enc[p] ^ fb_val[p][q];
         end
      end
   end

   // two live writes to one address
   always_comb
   begin
      wr_clash = 1'b0;
      for (int i = 0; i < W_PORTS; i++)
      begin
         for (int j = i + 1; j < W_PORTS; j++)
         begin
            if (wbe_q[i] != '0 && wbe_q[j] != '0 && waddr_q[i] == waddr_q[j])
            begin
               wr_clash = 1'b1;
            end
         end
      end
   end

   a_no_wr_clash: assert property (@(posedge clk) disable iff (!rstn) !wr_clash);
   a_port_range: assert property (@(posedge clk) W_PORTS >= 2 && W_PORTS <= MAX_W_PORTS);

endmodule

`default_nettype wire

// File: logic/xor_bank.sv
`default_nettype none

module xor_bank #(
   parameter int W_PORTS = 2,
   parameter int R_PORTS = 4
) (
   input  logic                                   clk,
   bank_wr_if.bank                                wr,
   input  regfile_types_pkg::addr_t [R_PORTS-1:0] raddr_i,
   input  logic [R_PORTS-1:0]                     ren_i,
   output regfile_types_pkg::data_t [R_PORTS-1:0] rd_data_o
);

   // copies that let the other write ports see this bank
   localparam int FB_N = W_PORTS - 1;

   // feedback copies
   // always reading, the encoder needs a value every cycle
   for (genvar j = 0; j < FB_N; j++)
   begin : g_fb
      sdp_bwe_ram fb_ram_inst (
         .clk      (clk),
         .a_addr_i (wr.waddr),
         .a_bwe_i  (wr.wbe),
         .a_data_i (wr.wdata),
         .b_addr_i (wr.fb_raddr[j]),
         .b_en_i   (1'b1),
         .b_data_o (wr.fb_rdata[j])
      );
   end

   // read copies, one per read port
   for (genvar i = 0; i < R_PORTS; i++)
   begin : g_rd
      sdp_bwe_ram rd_ram_inst (
         .clk      (clk),
         .a_addr_i (wr.waddr),
         .a_bwe_i  (wr.wbe),
         .a_data_i (wr.wdata),
         .b_addr_i (raddr_i[i]),
         .b_en_i   (ren_i[i]),
         .b_data_o (rd_data_o[i])
      );
   end

endmodule

`default_nettype wire

// File: logic/xor_regfile.sv
`default_nettype none

module xor_regfile #(
   parameter int W_PORTS = 2,
   parameter int R_PORTS = 4
) (
   input  logic                                   clk,
   input  logic                                   rstn,
   // write ports
   input  regfile_types_pkg::addr_t [W_PORTS-1:0] waddr_i,
   input  regfile_types_pkg::bwe_t  [W_PORTS-1:0] wbe_i,
   input  regfile_types_pkg::data_t [W_PORTS-1:0] wdata_i,
   // read ports
   input  regfile_types_pkg::addr_t [R_PORTS-1:0] raddr_i,
   input  logic [R_PORTS-1:0]                     ren_i,
   output regfile_types_pkg::data_t [R_PORTS-1:0] rdata_o,
   output logic [R_PORTS-1:0]                     rvalid_o
);
   import regfile_types_pkg::*;

   // read copy outputs of every bank
   data_t [W_PORTS-1:0][R_PORTS-1:0] bank_rd_data;

   // one write bundle per bank
   bank_wr_if #(.W_PORTS(W_PORTS)) bank_wr [W_PORTS] ();

   write_encoder #(
      .W_PORTS (W_PORTS)
   ) write_encoder_inst (
      .clk     (clk),
      .rstn    (rstn),
      .waddr_i (waddr_i),
      .wbe_i   (wbe_i),
      .wdata_i (wdata_i),
      .wr      (bank_wr)
   );

   for (genvar b = 0; b < W_PORTS; b++)
   begin : g_bank
      xor_bank #(
         .W_PORTS (W_PORTS),
         .R_PORTS (R_PORTS)
      ) xor_bank_inst (
         .clk       (clk),
         .wr        (bank_wr[b]),
         .raddr_i   (raddr_i),
         .ren_i     (ren_i),
         .rd_data_o (bank_rd_data[b])
      );
   end

   read_decoder #(
      .W_PORTS (W_PORTS),
      .R_PORTS (R_PORTS)
   ) read_decoder_inst (
      .clk         (clk),
      .rstn        (rstn),
      .ren_i       (ren_i),
      .bank_data_i (bank_rd_data),
      .rdata_o     (rdata_o),
      .rvalid_o    (rvalid_o)
   );

endmodule

`default_nettype wire

// File: testbench/tb_xor_regfile.sv
`default_nettype none

module tb_xor_regfile;
   import regfile_types_pkg::*;

   localparam int W_PORTS   = 2;
   localparam int R_PORTS   = 4;
   localparam int HALF_PER  = 10;
   localparam int RESET_CYC = 8;
   localparam int IDLE_CYC  = 4;
   localparam int FILL_CYC  = 2 * DEPTH;
   localparam int RAND_CYC  = 2000;
   localparam int MERGE_N   = 16;
   localparam int B2B_N     = 16;
   localparam int VIS_N     = 8;
   localparam int DRAIN_CYC = 4;
   localparam int MAX_CYC   = RESET_CYC + IDLE_CYC + FILL_CYC + RAND_CYC + 6 * MERGE_N
                            + 4 * B2B_N + (R_PORTS + 1) * VIS_N + DRAIN_CYC + 100;

   // expected read results of one sampling edge
   typedef struct packed {
      logic  [R_PORTS-1:0] vld;
      data_t [R_PORTS-1:0] dat;
   } rd_exp_t;

   logic                clk;
   logic                rstn;
   addr_t [W_PORTS-1:0] waddr;
   bwe_t  [W_PORTS-1:0] wbe;
   data_t [W_PORTS-1:0] wdata;
   addr_t [R_PORTS-1:0] raddr;
   logic  [R_PORTS-1:0] ren;
   data_t [R_PORTS-1:0] rdata;
   logic  [R_PORTS-1:0] rvalid;

   integer seed;
   int     cycle_cnt = 0;
   int     reads_checked;

   // reference model
   data_t model_mem [DEPTH];
   // writes captured one and two edges back and not yet visible to reads
   addr_t [W_PORTS-1:0] wa_d1;
   addr_t [W_PORTS-1:0] wa_d2;
   bwe_t  [W_PORTS-1:0] be_d1;
   bwe_t  [W_PORTS-1:0] be_d2;
   data_t [W_PORTS-1:0] wd_d1;
   data_t [W_PORTS-1:0] wd_d2;
   rd_exp_t             exp_q [$];

   xor_regfile #(
      .W_PORTS (W_PORTS),
      .R_PORTS (R_PORTS)
   ) xor_regfile_inst (
      .clk      (clk),
      .rstn     (rstn),
      .waddr_i  (waddr),
      .wbe_i    (wbe),
      .wdata_i  (wdata),
      .raddr_i  (raddr),
      .ren_i    (ren),
      .rdata_o  (rdata),
      .rvalid_o (rvalid)
   );

   initial
   begin
      clk = 1'b0;
      forever #HALF_PER clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYC)
      begin
         $display("sim failed");
         $fatal(1, "timeout, the run did not finish within %0d cycles", MAX_CYC);
      end
   end

   function automatic data_t rand_word();
      return $random(seed);
   endfunction

   // narrow draws stay in the low 16 registers to provoke collisions
   function automatic addr_t rand_addr(input logic narrow);
      logic [31:0] rnd;
      rnd = $random(seed);
      if (narrow)
         return addr_t'(rnd[3:0]);
      return rnd[ADDR_W-1:0];
   endfunction

   // never empty and never full
   function automatic bwe_t partial_be(input int k);
      return bwe_t'(1 + k % ((1 << NBYTES) - 2));
   endfunction

   function automatic void clear_inputs();
      wbe = '0;
      ren = '0;
   endfunction

   function automatic void apply_write(input addr_t a, input bwe_t be, input data_t d);
      for (int b = 0; b < NBYTES; b++)
         if (be[b])
            model_mem[a][b*BYTE_W +: BYTE_W] = d[b*BYTE_W +: BYTE_W];
   endfunction

   task automatic check(input string name, input data_t expected, input data_t actual);
      if (actual !== expected)
      begin
         $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
         $display("sim failed");
         $fatal(1, "%s does not match the model", name);
      end
   endtask

   // update the model and check the outputs over one clock
   task automatic step();
      rd_exp_t now_exp;
      rd_exp_t due;
      @(posedge clk);
      // writes captured two edges back are seen by this edge's reads
      for (int p = 0; p < W_PORTS; p++)
         apply_write(wa_d2[p], be_d2[p], wd_d2[p]);
      for (int r = 0; r < R_PORTS; r++)
      begin
         now_exp.vld[r] = rstn & ren[r];
         now_exp.dat[r] = model_mem[raddr[r]];
      end
      exp_q.push_back(now_exp);
      wa_d2 = wa_d1;
      be_d2 = be_d1;
      wd_d2 = wd_d1;
      wa_d1 = waddr;
      be_d1 = rstn ? wbe : '0;
      wd_d1 = wdata;
      #1;
      // result of the read sampled two edges back
      due = exp_q.pop_front();
      for (int r = 0; r < R_PORTS; r++)
      begin
         check($sformatf("rvalid_o[%0d]", r), data_t'(due.vld[r]), data_t'(rvalid[r]));
         if (due.vld[r])
         begin
            check($sformatf("rdata_o[%0d]", r), due.dat[r], rdata[r]);
            reads_checked++;
         end
      end
      #1;
   endtask

   task automatic fill_and_read();
      for (int i = 0; i < DEPTH; i++)
      begin
         clear_inputs();
         wbe[0]   = '1;
         waddr[0] = addr_t'(i);
         wdata[0] = rand_word();
         step();
      end
      for (int i = 0; i < DEPTH; i++)
      begin
         clear_inputs();
         for (int r = 0; r < R_PORTS; r++)
         begin
            ren[r]   = 1'b1;
            raddr[r] = addr_t'(i + r * (DEPTH / R_PORTS));
         end
         step();
      end
   endtask

   task automatic random_traffic();
      logic        narrow;
      logic        taken;
      logic [31:0] rnd;
      for (int c = 0; c < RAND_CYC; c++)
      begin
         narrow = (c >= RAND_CYC / 2);
         for (int p = 0; p < W_PORTS; p++)
         begin
            // write ports never share an address in one cycle
            taken = 1'b1;
            while (taken)
            begin
               waddr[p] = rand_addr(narrow);
               taken    = 1'b0;
               for (int q = 0; q < p; q++)
                  if (waddr[q] == waddr[p])
                     taken = 1'b1;
            end
            rnd      = $random(seed);
            wbe[p]   = rnd[NBYTES-1:0];
            wdata[p] = rand_word();
         end
         rnd = $random(seed);
         ren = rnd[R_PORTS-1:0];
         for (int r = 0; r < R_PORTS; r++)
            raddr[r] = rand_addr(narrow);
         step();
      end
   endtask

   task automatic byte_merge();
      addr_t a;
      int    full_p;
      int    part_p;
      for (int k = 0; k < MERGE_N; k++)
      begin
         a      = rand_addr(1'b0);
         full_p = k % W_PORTS;
         part_p = (k / 2) % W_PORTS;
         clear_inputs();
         wbe[full_p]   = '1;
         waddr[full_p] = a;
         wdata[full_p] = rand_word();
         step();
         clear_inputs();
         repeat (2) step();
         wbe[part_p]   = partial_be(k);
         waddr[part_p] = a;
         wdata[part_p] = rand_word();
         step();
         clear_inputs();
         step();
         ren   = '1;
         raddr = {R_PORTS{a}};
         step();
      end
   endtask

   task automatic back_to_back();
      addr_t a;
      int    first;
      int    second;
      for (int k = 0; k < B2B_N; k++)
      begin
         a      = rand_addr(1'b0);
         first  = k % W_PORTS;
         second = (first + 1) % W_PORTS;
         clear_inputs();
         wbe[first]   = '1;
         waddr[first] = a;
         wdata[first] = rand_word();
         step();
         // feedback of the first bank is stale here so the encoder must forward
         clear_inputs();
         wbe[second]   = partial_be(k);
         waddr[second] = a;
         wdata[second] = rand_word();
         step();
         clear_inputs();
         step();
         ren   = '1;
         raddr = {R_PORTS{a}};
         step();
      end
   endtask

   // read port r samples the register r cycles after the write's capture
   task automatic visibility();
      addr_t a;
      int    p;
      for (int k = 0; k < VIS_N; k++)
      begin
         a = rand_addr(1'b0);
         p = k % W_PORTS;
         clear_inputs();
         wbe[p]   = '1;
         waddr[p] = a;
         wdata[p] = model_mem[a] ^ (rand_word() | 32'h1);
         for (int c = 0; c < R_PORTS; c++)
         begin
            if (c > 0)
               clear_inputs();
            ren[c]   = 1'b1;
            raddr[c] = a;
            step();
         end
         clear_inputs();
         step();
      end
   endtask

   initial
   begin
      seed  = 45381;
      rstn  = 1'b0;
      waddr = '0;
      wdata = '0;
      raddr = '0;
      clear_inputs();
      // reads requested during reset must not raise rvalid_o
      ren   = '1;
      wa_d1 = '0;
      wa_d2 = '0;
      be_d1 = '0;
      be_d2 = '0;
      wd_d1 = '0;
      wd_d2 = '0;
      reads_checked = 0;
      // rvalid_o is checked from the first edge on
      exp_q.push_back('0);
      exp_q.push_back('0);

      repeat (RESET_CYC) step();
      rstn = 1'b1;
      clear_inputs();
      repeat (IDLE_CYC) step();

      fill_and_read();
      random_traffic();
      byte_merge();
      back_to_back();
      visibility();
      clear_inputs();
      repeat (DRAIN_CYC) step();

      if (reads_checked == 0)
      begin
         $display("sim failed");
         $fatal(1, "no read result reached the outputs");
      end
      else
      begin
         $display("sim passed");
         $finish;
      end
   end

endmodule

`default_nettype wire
